/* logic/lane_link_pkg.sv */
`default_nettype none

package lane_link_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Flit field widths
  localparam int STATE_W  = 4;
  localparam int PROTID_W = 2;
  localparam int DATA_W   = 32;
  localparam int CRC_W    = 8;
  localparam int FLIT_W   = STATE_W + PROTID_W + DATA_W + 1 + CRC_W + 1 + 1;

  // Bit offsets inside a packed flit word, lsb first
  localparam int FLIT_VALID_BIT  = 0;
  localparam int FLIT_CRCV_BIT   = 1;
  localparam int FLIT_CRC_LSB    = 2;
  localparam int FLIT_DVALID_BIT = FLIT_CRC_LSB + CRC_W;
  localparam int FLIT_DATA_LSB   = FLIT_DVALID_BIT + 1;
  localparam int FLIT_PROTID_LSB = FLIT_DATA_LSB + DATA_W;
  localparam int FLIT_STATE_LSB  = FLIT_PROTID_LSB + PROTID_W;

  ////////////////////////////////////////////////////////////////////////////
  // Lane word layout
  localparam int LANE_W           = 40;
  localparam int MARKER_W         = 2;
  localparam int LANE_STB_BIT     = 0;
  localparam int LANE_MRK_LSB     = 1;
  localparam int LANE_PAYLOAD_LSB = LANE_MRK_LSB + MARKER_W;
  localparam int LANE_PAYLOAD_W   = LANE_W - LANE_PAYLOAD_LSB;
  // Flit bits left over for lane 1
  localparam int LANE1_USED_W     = FLIT_W - LANE_PAYLOAD_W;

  // Misc widths
  localparam int DELAY_W     = 8;
  localparam int DEBUG_W     = 32;
  // Tx and rx online delay channels
  localparam int ONLINE_CH_N = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  typedef logic [STATE_W-1:0]  state_t;
  typedef logic [PROTID_W-1:0] protid_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [CRC_W-1:0]    crc_t;
  typedef logic [FLIT_W-1:0]   flit_word_t;
  typedef logic [LANE_W-1:0]   lane_word_t;
  typedef logic [MARKER_W-1:0] marker_t;
  typedef logic [DELAY_W-1:0]  delay_t;
  // One extra bit so the rx delay sum cannot wrap
  typedef logic [DELAY_W:0]    delay_sum_t;
  typedef logic [DEBUG_W-1:0]  debug_t;

endpackage

`default_nettype wire

/* logic/lane_flit_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface lane_flit_if;
  import lane_link_pkg::*;

  // Flit fields, one flit per cycle when valid is high
  state_t  state;
  protid_t protid;
  data_t   data;
  logic    dvalid;
  crc_t    crc;
  logic    crc_valid;
  logic    valid;

  // Producer side
  modport source (output state, protid, data, dvalid, crc, crc_valid, valid);

  // Consumer side
  modport sink (input state, protid, data, dvalid, crc, crc_valid, valid);

endinterface

`default_nettype wire

/* logic/lane_auto_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_auto_sync (
  input  logic                   clk_wr,
  input  logic                   rst_n,

  // Raw online levels
  input  logic                   tx_online,
  input  logic                   rx_online,

  // Delay configuration
  input  lane_link_pkg::delay_t  delay_x_value,
  input  lane_link_pkg::delay_t  delay_xz_value,
  input  lane_link_pkg::delay_t  delay_yz_value,

  // User bit configuration
  input  lane_link_pkg::marker_t tx_mrk_userbit,
  input  logic                   tx_stb_userbit,

  // Delayed levels and user bits toward the lanes
  output logic                   tx_online_delay,
  output logic                   rx_online_delay,
  output logic                   tx_auto_stb_userbit,
  output lane_link_pkg::marker_t tx_auto_mrk_userbit
);
  import lane_link_pkg::*;

  // Channel 0 is tx, channel 1 is rx
  delay_sum_t             sync_cnt    [ONLINE_CH_N];
  delay_sum_t             sync_target [ONLINE_CH_N];
  logic [ONLINE_CH_N-1:0] online_in;
  logic [ONLINE_CH_N-1:0] online_delay;

  assign online_in = {rx_online, tx_online};

  // Tx waits xz, rx waits x plus yz
  assign sync_target[0] = delay_sum_t'(delay_xz_value);
  assign sync_target[1] = delay_sum_t'(delay_x_value) + delay_sum_t'(delay_yz_value);

  ////////////////////////////////////////////////////////////////////////////
  // Saturating delay counters
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      for (int ch = 0; ch < ONLINE_CH_N; ch++) begin
        sync_cnt[ch] <= '0;
      end
      online_delay <= '0;
    end else begin
      for (int ch = 0; ch < ONLINE_CH_N; ch++) begin
        if (!online_in[ch]) begin
          // Drop at once when the link goes away
          sync_cnt[ch]     <= '0;
          online_delay[ch] <= 1'b0;
        end else if (sync_cnt[ch] >= sync_target[ch]) begin
          // Count done, hold here
          online_delay[ch] <= 1'b1;
        end else begin
          sync_cnt[ch] <= sync_cnt[ch] + 1'b1;
        end
      end
    end
  end

  assign tx_online_delay = online_delay[0];
  assign rx_online_delay = online_delay[1];

  ////////////////////////////////////////////////////////////////////////////
  // Persistent user bits
  // Same strobe and marker on every word while tx is up
  assign tx_auto_stb_userbit = tx_online_delay & tx_stb_userbit;
  assign tx_auto_mrk_userbit = tx_online_delay ? tx_mrk_userbit : '0;

endmodule

`default_nettype wire

/* logic/lane_tx_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_tx_stage (
  input  logic                   clk_wr,
  input  logic                   rst_n,

  // Upstream flit
  input  lane_link_pkg::state_t  ustrm_state,
  input  lane_link_pkg::protid_t ustrm_protid,
  input  lane_link_pkg::data_t   ustrm_data,
  input  logic                   ustrm_dvalid,
  input  lane_link_pkg::crc_t    ustrm_crc,
  input  logic                   ustrm_crc_valid,
  input  logic                   ustrm_valid,

  // Registered flit toward the lane mapper
  lane_flit_if.source            tx_flit,

  // Sent flit count
  output lane_link_pkg::debug_t  tx_upstream_debug_status
);

  ////////////////////////////////////////////////////////////////////////////
  // Valid strobes
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_flit.valid     <= 1'b0;
      tx_flit.dvalid    <= 1'b0;
      tx_flit.crc_valid <= 1'b0;
    end else begin
      tx_flit.valid     <= ustrm_valid;
      tx_flit.dvalid    <= ustrm_dvalid;
      tx_flit.crc_valid <= ustrm_crc_valid;
    end
  end

  // Payload fields, qualified by the strobes above
  always_ff @(posedge clk_wr) begin
    tx_flit.state  <= ustrm_state;
    tx_flit.protid <= ustrm_protid;
    tx_flit.data   <= ustrm_data;
    tx_flit.crc    <= ustrm_crc;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Debug count of upstream flits
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_upstream_debug_status <= '0;
    end else if (ustrm_valid) begin
      tx_upstream_debug_status <= tx_upstream_debug_status + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/lane_phy_concat.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_phy_concat (
  input  logic                      clk_wr,
  input  logic                      rst_n,

  // Flit to send and flit rebuilt
  lane_flit_if.sink                 tx_flit,
  lane_flit_if.source               rx_flit,

  // Delayed online level and user bits
  input  logic                      tx_online,
  input  logic                      tx_stb_userbit,
  input  lane_link_pkg::marker_t    tx_mrk_userbit,

  // PHY lanes
  output lane_link_pkg::lane_word_t tx_phy0,
  output lane_link_pkg::lane_word_t tx_phy1,
  input  lane_link_pkg::lane_word_t rx_phy0,
  input  lane_link_pkg::lane_word_t rx_phy1
);
  import lane_link_pkg::*;

  flit_word_t                tx_word;
  flit_word_t                rx_word;
  logic [LANE_PAYLOAD_W-1:0] tx_payload0;
  logic [LANE_PAYLOAD_W-1:0] tx_payload1;
  lane_word_t                rx_phy0_q;
  lane_word_t                rx_phy1_q;
  logic                      rx_stb_ok;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit side
  // Pack, valid in bit 0
  assign tx_word = {tx_flit.state, tx_flit.protid, tx_flit.data, tx_flit.dvalid,
                    tx_flit.crc, tx_flit.crc_valid, tx_flit.valid};

  // Low flit bits on lane 0, the rest on lane 1
  // Quiet lanes until tx is online
  assign tx_payload0 = tx_online ? tx_word[LANE_PAYLOAD_W-1:0] : '0;
  assign tx_payload1 = tx_online ?
                       {{(LANE_PAYLOAD_W - LANE1_USED_W){1'b0}},
                        tx_word[FLIT_W-1:LANE_PAYLOAD_W]} : '0;

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      // Both lanes carry the same user bits
      tx_phy0[LANE_STB_BIT]                       <= tx_stb_userbit;
      tx_phy0[LANE_MRK_LSB +: MARKER_W]           <= tx_mrk_userbit;
      tx_phy0[LANE_PAYLOAD_LSB +: LANE_PAYLOAD_W] <= tx_payload0;
      tx_phy1[LANE_STB_BIT]                       <= tx_stb_userbit;
      tx_phy1[LANE_MRK_LSB +: MARKER_W]           <= tx_mrk_userbit;
      tx_phy1[LANE_PAYLOAD_LSB +: LANE_PAYLOAD_W] <= tx_payload1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive side
  // Capture the lanes, cleared so no stale strobe after reset
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_phy0_q <= '0;
      rx_phy1_q <= '0;
    end else begin
      rx_phy0_q <= rx_phy0;
      rx_phy1_q <= rx_phy1;
    end
  end

  // Glue lane payloads back together
  assign rx_word = {rx_phy1_q[LANE_PAYLOAD_LSB +: LANE1_USED_W],
                    rx_phy0_q[LANE_PAYLOAD_LSB +: LANE_PAYLOAD_W]};

  // Flit is good only when both lanes strobe
  assign rx_stb_ok = rx_phy0_q[LANE_STB_BIT] & rx_phy1_q[LANE_STB_BIT];

  // Unpack
  assign rx_flit.state     = rx_word[FLIT_STATE_LSB +: STATE_W];
  assign rx_flit.protid    = rx_word[FLIT_PROTID_LSB +: PROTID_W];
  assign rx_flit.data      = rx_word[FLIT_DATA_LSB +: DATA_W];
  assign rx_flit.crc       = rx_word[FLIT_CRC_LSB +: CRC_W];
  assign rx_flit.dvalid    = rx_word[FLIT_DVALID_BIT] & rx_stb_ok;
  assign rx_flit.crc_valid = rx_word[FLIT_CRCV_BIT] & rx_stb_ok;
  assign rx_flit.valid     = rx_word[FLIT_VALID_BIT] & rx_stb_ok;

endmodule

`default_nettype wire

/* logic/lane_rx_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_rx_stage (
  input  logic                   clk_wr,
  input  logic                   rst_n,
  // Delayed rx online level
  input  logic                   rx_online,

  // Rebuilt flit from the lanes
  lane_flit_if.sink              rx_flit,

  // Downstream flit
  output lane_link_pkg::state_t  dstrm_state,
  output lane_link_pkg::protid_t dstrm_protid,
  output lane_link_pkg::data_t   dstrm_data,
  output logic                   dstrm_dvalid,
  output lane_link_pkg::crc_t    dstrm_crc,
  output logic                   dstrm_crc_valid,
  output logic                   dstrm_valid,

  // Delivered flit count
  output lane_link_pkg::debug_t  rx_downstream_debug_status
);

  ////////////////////////////////////////////////////////////////////////////
  // Valid strobes, held low until rx is online
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      dstrm_valid     <= 1'b0;
      dstrm_dvalid    <= 1'b0;
      dstrm_crc_valid <= 1'b0;
    end else begin
      dstrm_valid     <= rx_flit.valid & rx_online;
      dstrm_dvalid    <= rx_flit.dvalid & rx_online;
      dstrm_crc_valid <= rx_flit.crc_valid & rx_online;
    end
  end

  // Payload passes through untouched
  always_ff @(posedge clk_wr) begin
    dstrm_state  <= rx_flit.state;
    dstrm_protid <= rx_flit.protid;
    dstrm_data   <= rx_flit.data;
    dstrm_crc    <= rx_flit.crc;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Debug count, moves together with dstrm_valid
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_downstream_debug_status <= '0;
    end else if (rx_flit.valid && rx_online) begin
      rx_downstream_debug_status <= rx_downstream_debug_status + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/lane_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_link_top (
  input  logic                      clk_wr,
  input  logic                      rst_n,

  // Control
  input  logic                      tx_online,
  input  logic                      rx_online,

  // PHY lanes
  output lane_link_pkg::lane_word_t tx_phy0,
  output lane_link_pkg::lane_word_t tx_phy1,
  input  lane_link_pkg::lane_word_t rx_phy0,
  input  lane_link_pkg::lane_word_t rx_phy1,

  // Downstream
  output lane_link_pkg::state_t     dstrm_state,
  output lane_link_pkg::protid_t    dstrm_protid,
  output lane_link_pkg::data_t      dstrm_data,
  output logic                      dstrm_dvalid,
  output lane_link_pkg::crc_t       dstrm_crc,
  output logic                      dstrm_crc_valid,
  output logic                      dstrm_valid,

  // Upstream
  input  lane_link_pkg::state_t     ustrm_state,
  input  lane_link_pkg::protid_t    ustrm_protid,
  input  lane_link_pkg::data_t      ustrm_data,
  input  logic                      ustrm_dvalid,
  input  lane_link_pkg::crc_t       ustrm_crc,
  input  logic                      ustrm_crc_valid,
  input  logic                      ustrm_valid,

  // Debug
  output lane_link_pkg::debug_t     rx_downstream_debug_status,
  output lane_link_pkg::debug_t     tx_upstream_debug_status,

  // Configuration
  input  lane_link_pkg::marker_t    tx_mrk_userbit,
  input  logic                      tx_stb_userbit,
  input  lane_link_pkg::delay_t     delay_x_value,
  input  lane_link_pkg::delay_t     delay_xz_value,
  input  lane_link_pkg::delay_t     delay_yz_value
);
  import lane_link_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Internal wiring
  logic    tx_online_delay;
  logic    rx_online_delay;
  logic    tx_auto_stb_userbit;
  marker_t tx_auto_mrk_userbit;

  lane_flit_if tx_flit ();
  lane_flit_if rx_flit ();

  ////////////////////////////////////////////////////////////////////////////
  // Online delay and user bits
  lane_auto_sync u_lane_auto_sync (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_xz_value      (delay_xz_value),
    .delay_yz_value      (delay_yz_value),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit)
  );

  // Upstream capture
  lane_tx_stage u_lane_tx_stage (
    .clk_wr                   (clk_wr),
    .rst_n                    (rst_n),
    .ustrm_state              (ustrm_state),
    .ustrm_protid             (ustrm_protid),
    .ustrm_data               (ustrm_data),
    .ustrm_dvalid             (ustrm_dvalid),
    .ustrm_crc                (ustrm_crc),
    .ustrm_crc_valid          (ustrm_crc_valid),
    .ustrm_valid              (ustrm_valid),
    .tx_flit                  (tx_flit.source),
    .tx_upstream_debug_status (tx_upstream_debug_status)
  );

  // Lane mapping, both directions
  lane_phy_concat u_lane_phy_concat (
    .clk_wr         (clk_wr),
    .rst_n          (rst_n),
    .tx_flit        (tx_flit.sink),
    .rx_flit        (rx_flit.source),
    .tx_online      (tx_online_delay),
    .tx_stb_userbit (tx_auto_stb_userbit),
    .tx_mrk_userbit (tx_auto_mrk_userbit),
    .tx_phy0        (tx_phy0),
    .tx_phy1        (tx_phy1),
    .rx_phy0        (rx_phy0),
    .rx_phy1        (rx_phy1)
  );

  // Downstream delivery
  lane_rx_stage u_lane_rx_stage (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .rx_online                  (rx_online_delay),
    .rx_flit                    (rx_flit.sink),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .rx_downstream_debug_status (rx_downstream_debug_status)
  );

endmodule

`default_nettype wire

/* verif/lane_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_clk_gen (
  output logic clk
);

  // 100 ns period, low at time zero
  initial clk = 1'b0;

  always #50 clk = ~clk;

endmodule

`default_nettype wire

/* verif/lane_link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_link_tb;
  import lane_link_pkg::*;

  // Tests file layout, in tokens
  localparam int HDR_LEN   = 6;
  localparam int VEC_LEN   = 16;
  localparam int MEM_DEPTH = 1024;

  logic       clk;
  logic       rst_n;
  logic       tx_online;
  logic       rx_online;
  lane_word_t tx_phy0;
  lane_word_t tx_phy1;
  state_t     dstrm_state;
  protid_t    dstrm_protid;
  data_t      dstrm_data;
  logic       dstrm_dvalid;
  crc_t       dstrm_crc;
  logic       dstrm_crc_valid;
  logic       dstrm_valid;
  state_t     ustrm_state;
  protid_t    ustrm_protid;
  data_t      ustrm_data;
  logic       ustrm_dvalid;
  crc_t       ustrm_crc;
  logic       ustrm_crc_valid;
  logic       ustrm_valid;
  debug_t     rx_downstream_debug_status;
  debug_t     tx_upstream_debug_status;
  marker_t    tx_mrk_userbit;
  logic       tx_stb_userbit;
  delay_t     delay_x_value;
  delay_t     delay_xz_value;
  delay_t     delay_yz_value;

  logic [31:0] tests_mem [0:MEM_DEPTH-1];
  // Consecutive tx_online vectors ending at each vector
  int          tx_run_len [0:MEM_DEPTH-1];
  // Vector indices still in the 4-stage loopback pipe
  int          exp_q [$];
  int          vec_cnt;
  int          sent_cnt    = 0;
  int          seen_cnt    = 0;
  int          cycle_cnt   = 0;
  int          cycle_limit = 1000;

  lane_clk_gen u_lane_clk_gen (
    .clk (clk)
  );

  // Lanes looped straight back
  lane_link_top u_lane_link_top (
    .clk_wr                     (clk),
    .rst_n                      (rst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .tx_phy0                    (tx_phy0),
    .tx_phy1                    (tx_phy1),
    .rx_phy0                    (tx_phy0),
    .rx_phy1                    (tx_phy1),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_crc_valid            (ustrm_crc_valid),
    .ustrm_valid                (ustrm_valid),
    .rx_downstream_debug_status (rx_downstream_debug_status),
    .tx_upstream_debug_status   (tx_upstream_debug_status),
    .tx_mrk_userbit             (tx_mrk_userbit),
    .tx_stb_userbit             (tx_stb_userbit),
    .delay_x_value              (delay_x_value),
    .delay_xz_value             (delay_xz_value),
    .delay_yz_value             (delay_yz_value)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error %s got %0h exp %0h", name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // Tx lanes carry a flit once tx has been up past the xz delay
  function automatic bit tx_flit_online(input int idx);
    if (idx < 0) begin
      return 1'b0;
    end else begin
      return tx_run_len[idx] > int'(delay_xz_value);
    end
  endfunction

  task automatic drive_vector(input int idx);
    int base;
    base = HDR_LEN + idx * VEC_LEN;
    tx_online       <= tests_mem[base][0];
    rx_online       <= tests_mem[base+1][0];
    ustrm_state     <= tests_mem[base+2][STATE_W-1:0];
    ustrm_protid    <= tests_mem[base+3][PROTID_W-1:0];
    ustrm_data      <= tests_mem[base+4];
    ustrm_dvalid    <= tests_mem[base+5][0];
    ustrm_crc       <= tests_mem[base+6][CRC_W-1:0];
    ustrm_crc_valid <= tests_mem[base+7][0];
    ustrm_valid     <= tests_mem[base+8][0];
  endtask

  task automatic verify_cycle(input int idx);
    int   line;
    int   base;
    logic gate;
    // Lane words lag the driven vector by two edges
    gate = tx_flit_online(idx - 2);
    check_value("tx_phy0_strobe", tx_phy0[LANE_STB_BIT], gate & tx_stb_userbit);
    check_value("tx_phy1_strobe", tx_phy1[LANE_STB_BIT], gate & tx_stb_userbit);
    check_value("tx_phy0_marker", tx_phy0[LANE_MRK_LSB +: MARKER_W],
                gate ? tx_mrk_userbit : 2'b00);
    check_value("tx_phy1_marker", tx_phy1[LANE_MRK_LSB +: MARKER_W],
                gate ? tx_mrk_userbit : 2'b00);
    // Flit driven four edges back
    if (exp_q.size() > 4) begin
      line = exp_q.pop_front();
      base = HDR_LEN + line * VEC_LEN;
      check_value("dstrm_state", dstrm_state, tests_mem[base+9]);
      check_value("dstrm_protid", dstrm_protid, tests_mem[base+10]);
      check_value("dstrm_data", dstrm_data, tests_mem[base+11]);
      check_value("dstrm_dvalid", dstrm_dvalid, tests_mem[base+12]);
      check_value("dstrm_crc", dstrm_crc, tests_mem[base+13]);
      check_value("dstrm_crc_valid", dstrm_crc_valid, tests_mem[base+14]);
      check_value("dstrm_valid", dstrm_valid, tests_mem[base+15]);
      seen_cnt += tests_mem[base+15][0];
    end else begin
      // Pipe still filling, nothing delivered yet
      check_value("dstrm_valid", dstrm_valid, 0);
      check_value("dstrm_dvalid", dstrm_dvalid, 0);
      check_value("dstrm_crc_valid", dstrm_crc_valid, 0);
    end
    // Debug counters
    check_value("tx_upstream_debug_status", tx_upstream_debug_status, sent_cnt);
    check_value("rx_downstream_debug_status", rx_downstream_debug_status, seen_cnt);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  initial begin
    int base;
    $readmemh("verif/lane_link_tests.txt", tests_mem);
    // Config from the header line
    delay_x_value   = tests_mem[0][DELAY_W-1:0];
    delay_xz_value  = tests_mem[1][DELAY_W-1:0];
    delay_yz_value  = tests_mem[2][DELAY_W-1:0];
    tx_mrk_userbit  = tests_mem[3][MARKER_W-1:0];
    tx_stb_userbit  = tests_mem[4][0];
    vec_cnt         = tests_mem[5];
    cycle_limit     = 2 * (vec_cnt + 64);
    rst_n           = 1'b0;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    ustrm_state     = '0;
    ustrm_protid    = '0;
    ustrm_data      = '0;
    ustrm_dvalid    = 1'b0;
    ustrm_crc       = '0;
    ustrm_crc_valid = 1'b0;
    ustrm_valid     = 1'b0;
    if (vec_cnt <= 0) begin
      $display("No test vectors were loaded from the tests file");
      $display("Testbench failed");
      $fatal(1);
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    // Reset state
    @(negedge clk);
    check_value("dstrm_valid", dstrm_valid, 0);
    check_value("dstrm_dvalid", dstrm_dvalid, 0);
    check_value("dstrm_crc_valid", dstrm_crc_valid, 0);
    check_value("tx_phy0", tx_phy0, 0);
    check_value("tx_phy1", tx_phy1, 0);
    check_value("tx_upstream_debug_status", tx_upstream_debug_status, 0);
    check_value("rx_downstream_debug_status", rx_downstream_debug_status, 0);
    for (int i = 0; i < vec_cnt; i++) begin
      base = HDR_LEN + i * VEC_LEN;
      @(posedge clk);
      drive_vector(i);
      if (tests_mem[base][0]) begin
        tx_run_len[i] = (i > 0) ? tx_run_len[i-1] + 1 : 1;
      end else begin
        tx_run_len[i] = 0;
      end
      exp_q.push_back(i);
      @(negedge clk);
      verify_cycle(i);
      // Counter sees this vector on the next edge
      sent_cnt += tests_mem[base+8][0];
    end
    $display("Testbench passed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, the vector loop never finished", cycle_cnt);
      $display("Testbench failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* verif/lane_link_tests.txt */
// Header: delay_x delay_xz delay_yz marker strobe vector_count
// Vector: tx_on rx_on state protid data dvalid crc crc_valid valid, then expected dstrm same order
01 02 02 2 1 16
1 1 1 0 11111111 1 a1 1 1  0 0 00000000 0 00 0 0
1 1 2 1 22222222 0 b2 1 1  0 0 00000000 0 00 0 0
1 1 3 2 deadbeef 1 c3 1 1  3 2 deadbeef 1 c3 1 1
1 1 4 3 cafef00d 1 d4 0 1  4 3 cafef00d 1 d4 0 1
1 1 5 0 0badc0de 0 e5 1 1  5 0 0badc0de 0 e5 1 1
1 1 6 1 12345678 1 f6 1 0  6 1 12345678 1 f6 1 0
1 1 7 2 89abcdef 0 07 0 0  7 2 89abcdef 0 07 0 0
1 1 8 3 ffffffff 1 ff 1 1  8 3 ffffffff 1 ff 1 1
1 1 f 0 a5a5a5a5 1 18 1 1  f 0 a5a5a5a5 1 18 1 1
0 1 9 1 5a5a5a5a 1 29 1 1  0 0 00000000 0 00 0 0
1 1 a 2 13572468 1 3a 1 1  0 0 00000000 0 00 0 0
1 1 b 3 24681357 1 4b 1 1  0 0 00000000 0 00 0 0
1 0 c 0 76543210 1 5c 1 1  c 0 76543210 0 5c 0 0
1 0 d 1 fedcba98 1 6d 1 1  d 1 fedcba98 0 6d 0 0
1 1 e 2 01234567 1 7e 1 1  e 2 01234567 0 7e 0 0
1 1 0 3 c0ffee00 1 8f 1 1  0 3 c0ffee00 1 8f 1 1
1 1 1 1 600dcafe 0 90 1 1  1 1 600dcafe 0 90 1 1
1 1 2 2 87654321 1 a0 0 1  2 2 87654321 1 a0 0 1
1 1 0 0 00000000 0 00 0 0  0 0 00000000 0 00 0 0
1 1 0 0 00000000 0 00 0 0  0 0 00000000 0 00 0 0
1 1 0 0 00000000 0 00 0 0  0 0 00000000 0 00 0 0
1 1 0 0 00000000 0 00 0 0  0 0 00000000 0 00 0 0

/* lane_link.f */
logic/lane_link_pkg.sv
logic/lane_flit_if.sv
logic/lane_auto_sync.sv
logic/lane_tx_stage.sv
logic/lane_phy_concat.sv
logic/lane_rx_stage.sv
logic/lane_link_top.sv
verif/lane_clk_gen.sv
verif/lane_link_tb.sv
